// ==== test/cache_mem_model.sv ====
// ----------------------------------------------------------------------
// Line-wide memory of 4 KiB; address bits above 11 are ignored.
// One request at a time, and a write is answered with an empty line.
// ----------------------------------------------------------------------
`default_nettype none

module cache_mem_model
  import cache_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          memreq_val,
  output logic          memreq_rdy,
  input  line_req_t     memreq,
  output logic          memresp_val,
  input  logic          memresp_rdy,
  output line_resp_t    memresp,
  output logic [255:0]  line_written
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [LINE_W-1:0] lines [0:255];
  integer            seed;
  logic [31:0]       rnd;
  logic              req_fire;
  logic              resp_fire;
  line_req_t         req_seen;
  logic              busy;
  logic [1:0]        delay;
  logic [7:0]        line_idx;

  function automatic logic [DATA_W-1:0] initial_word(input logic [11:0] a);
    return {a[11:2], 2'b01, ~a[11:2], 2'b10, a[9:2]};
  endfunction

  initial begin
    seed         = 32'h85647d76;
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp      = '0;
    line_written = '0;
    busy         = 1'b0;
    delay        = 2'd0;
    req_fire     = 1'b0;
    resp_fire    = 1'b0;
    req_seen     = '0;
    for (int i = 0; i < 256; i++) begin
      for (int k = 0; k < WORDS_PER_LINE; k++) begin
        lines[i][k*DATA_W +: DATA_W] = initial_word({i[7:0], k[1:0], 2'b00});
      end
    end
  end

  // Handshakes seen on the rising edge
  always @(posedge clk) begin
    req_fire  = memreq_val && memreq_rdy;
    resp_fire = memresp_val && memresp_rdy;
    req_seen  = memreq;
  end

  always @(negedge clk) begin
    if (reset) begin
      memreq_rdy  = 1'b0;
      memresp_val = 1'b0;
      busy        = 1'b0;
    end else begin
      if (resp_fire) begin
        memresp_val = 1'b0;
        busy        = 1'b0;
      end
      if (req_fire) begin
        line_idx = req_seen.addr[11:4];
        if (req_seen.mem_type == MEM_WRITE) begin
          lines[line_idx]        = req_seen.data;
          line_written[line_idx] = 1'b1;
          memresp.data           = '0;
        end else begin
          memresp.data = lines[line_idx];
        end
        rnd        = $random(seed);
        delay      = rnd[1:0];
        busy       = 1'b1;
        memreq_rdy = 1'b0;
      end
      // Response after 0 to 3 cycles
      if (busy && !memresp_val) begin
        if (delay == 2'd0) begin
          memresp_val = 1'b1;
        end else begin
          delay = delay - 2'd1;
        end
      end
      if (!busy) begin
        rnd        = $random(seed);
        memreq_rdy = (rnd[1:0] != 2'b00);
      end
    end
  end

endmodule

`default_nettype wire

// ==== test/cache_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for the blocking cache. All addresses stay below 4 KiB;
// lines installed by WRITE_INIT are read back only at the written word.
// ----------------------------------------------------------------------
`default_nettype none

module cache_tb
  import cache_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 200;

  logic          clk;
  logic          reset;
  logic          cachereq_val;
  logic          cachereq_rdy;
  cache_req_t    cachereq;
  logic          cacheresp_val;
  logic          cacheresp_rdy;
  cache_resp_t   cacheresp;
  logic          memreq_val;
  logic          memreq_rdy;
  line_req_t     memreq;
  logic          memresp_val;
  logic          memresp_rdy;
  line_resp_t    memresp;
  logic [255:0]  line_written;

  logic [DATA_W-1:0]  ref_mem [0:1023];
  cache_resp_t        expected_q [$];
  logic [ADDR_W-1:0]  addr_q [$];
  cache_resp_t        want;
  logic [ADDR_W-1:0]  want_addr;
  logic               stall_resp;
  logic               stall_now;
  integer             stall_seed;
  integer             stim_seed;
  logic [31:0]        stall_rnd;
  logic [31:0]        rnd_word;
  logic [2:0]         rnd_set;
  req_type_e          rnd_op;
  int                 checked;
  int                 value_errors;
  int                 other_errors;
  int                 timeouts;

  blocking_cache #(
    .idx_shamt (0)
  ) blocking_cache_i (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cachereq      (cachereq),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .cacheresp     (cacheresp),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq        (memreq),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .memresp       (memresp)
  );

  cache_mem_model mem_i (
    .clk          (clk),
    .reset        (reset),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq       (memreq),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp      (memresp),
    .line_written (line_written)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  // Power-up contents of memory, a function of the whole address
  function automatic logic [DATA_W-1:0] fill_word(input logic [11:0] a);
    return {a[11:2], 2'b01, ~a[11:2], 2'b10, a[9:2]};
  endfunction

  function automatic cache_resp_t model_request(input cache_req_t req);
    cache_resp_t       resp;
    logic [9:0]        w;
    logic [DATA_W-1:0] old;
    w              = req.addr[11:2];
    old            = ref_mem[w];
    resp.resp_type = req.req_type;
    resp.data      = old;
    case (req.req_type)
      WRITE, WRITE_INIT: begin
        ref_mem[w] = req.data;
        resp.data  = '0;
      end
      AMO_ADD: ref_mem[w] = old + req.data;
      AMO_AND: ref_mem[w] = old & req.data;
      AMO_OR:  ref_mem[w] = old | req.data;
      default: resp.data = old;
    endcase
    return resp;
  endfunction

  // ----------------------------------------------------------------------
  // Stimulus helpers, entered and left on a falling edge
  // ----------------------------------------------------------------------

  task automatic send_req(input req_type_e op, input logic [31:0] addr,
                          input logic [31:0] data);
    cache_req_t req;
    int         cycles;
    logic       taken;
    req.req_type = op;
    req.addr     = addr;
    req.data     = data;
    cachereq     = req;
    cachereq_val = 1'b1;
    taken        = 1'b0;
    cycles       = 0;
    while (!taken && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      if (cachereq_rdy) begin
        taken = 1'b1;
        expected_q.push_back(model_request(req));
        addr_q.push_back(addr);
      end
      @(negedge clk);
      cycles++;
    end
    cachereq_val = 1'b0;
    if (!taken) begin
      timeouts++;
      $display("Timeout: the cache never accepted opcode %0d to %h", op, addr);
    end
  endtask

  task automatic drain_responses();
    int cycles;
    cycles = 0;
    while (expected_q.size() != 0 && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (expected_q.size() != 0) begin
      timeouts++;
      $display("Timeout: %0d responses never arrived", expected_q.size());
    end
  endtask

  // Response ready, random while stalling is on
  initial begin
    cacheresp_rdy = 1'b0;
    stall_seed    = 32'h85647d76;
    forever begin
      @(posedge clk);
      stall_now = stall_resp;
      @(negedge clk);
      if (stall_now) begin
        stall_rnd     = $random(stall_seed);
        cacheresp_rdy = stall_rnd[0];
      end else begin
        cacheresp_rdy = 1'b1;
      end
    end
  end

  // Compare each taken response with the oldest expected one
  always @(posedge clk) begin
    if (!reset && cacheresp_val && cacheresp_rdy) begin
      if (expected_q.size() == 0) begin
        other_errors++;
        $display("The cache sent a response that no request asked for at %0t", $time);
      end else begin
        want      = expected_q.pop_front();
        want_addr = addr_q.pop_front();
        checked++;
        assert (cacheresp.resp_type === want.resp_type) else begin
          value_errors++;
          $display("[FAIL] %0t: addr %h opcode %0d, expected %0d", $time, want_addr,
                   cacheresp.resp_type, want.resp_type);
        end
        assert (cacheresp.data === want.data) else begin
          value_errors++;
          $display("[FAIL] %0t: addr %h data %h, expected %h", $time, want_addr,
                   cacheresp.data, want.data);
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------

  initial begin
    reset        = 1'b1;
    cachereq_val = 1'b0;
    cachereq     = '0;
    stall_resp   = 1'b0;
    stim_seed    = 32'h85647d76;
    checked      = 0;
    value_errors = 0;
    other_errors = 0;
    timeouts     = 0;
    for (int i = 0; i < 1024; i++) begin
      ref_mem[i] = fill_word({i[9:0], 2'b00});
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;

    // Refill on reads
    send_req(READ, 32'h000, 32'h0);
    send_req(READ, 32'h014, 32'h0);
    send_req(READ, 32'h008, 32'h0);

    // Write then read, neighbors untouched
    send_req(WRITE, 32'h024, 32'hdeadbeef);
    send_req(READ, 32'h024, 32'h0);
    send_req(READ, 32'h020, 32'h0);
    send_req(READ, 32'h028, 32'h0);
    send_req(READ, 32'h02c, 32'h0);

    // Three lines in set 3, the third write evicts line 0x030
    send_req(WRITE, 32'h030, 32'h0a0a0a0a);
    send_req(WRITE, 32'h134, 32'h0b0b0b0b);
    send_req(WRITE, 32'h238, 32'h0c0c0c0c);
    drain_responses();
    assert (line_written[8'h03]) else begin
      other_errors++;
      $display("Memory never received the write-back of the line at 0x030");
    end
    send_req(READ, 32'h030, 32'h0);
    send_req(READ, 32'h134, 32'h0);
    send_req(READ, 32'h238, 32'h0);
    send_req(READ, 32'h03c, 32'h0);

    // Atomics
    send_req(AMO_ADD, 32'h040, 32'h11111111);
    send_req(READ, 32'h040, 32'h0);
    send_req(AMO_AND, 32'h044, 32'h0ff00ff0);
    send_req(READ, 32'h044, 32'h0);
    send_req(AMO_OR, 32'h048, 32'h80000001);
    send_req(READ, 32'h048, 32'h0);
    send_req(AMO_ADD, 32'h040, 32'hffffffff);
    send_req(READ, 32'h040, 32'h0);

    // WRITE_INIT in sets 5 to 7 with responses held back
    stall_resp = 1'b1;
    send_req(WRITE_INIT, 32'h050, fill_word(12'h050));
    send_req(WRITE_INIT, 32'h154, fill_word(12'h154));
    send_req(WRITE_INIT, 32'h064, fill_word(12'h064));
    send_req(WRITE_INIT, 32'h07c, fill_word(12'h07c));
    send_req(READ, 32'h050, 32'h0);
    send_req(READ, 32'h154, 32'h0);
    send_req(READ, 32'h064, 32'h0);
    send_req(READ, 32'h07c, 32'h0);
    send_req(READ, 32'h258, 32'h0);
    send_req(READ, 32'h050, 32'h0);

    // Random traffic confined to sets 0 to 4
    for (int n = 0; n < 40; n++) begin
      rnd_word = $random(stim_seed);
      rnd_set  = rnd_word[10:8] % 5;
      case (rnd_word[18:16])
        3'd2, 3'd3: rnd_op = WRITE;
        3'd4:       rnd_op = AMO_ADD;
        3'd5:       rnd_op = AMO_AND;
        3'd6:       rnd_op = AMO_OR;
        default:    rnd_op = READ;
      endcase
      send_req(rnd_op, {23'd0, rnd_word[13:12], rnd_set, rnd_word[3:2], 2'b00},
               $random(stim_seed));
    end
    drain_responses();

    $display("Responses checked: %0d, value errors: %0d, other errors: %0d, timeouts: %0d",
             checked, value_errors, other_errors, timeouts);
    if (value_errors == 0 && other_errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/cache_pkg.sv
verilog/cache_state_bits.sv
verilog/cache_ctrl.sv
verilog/cache_dpath.sv
verilog/blocking_cache.sv
test/cache_mem_model.sv
test/cache_tb.sv

// ==== verilog/blocking_cache.sv ====
// ----------------------------------------------------------------------
// Two-way blocking write-back cache, 256 bytes, one request in flight.
// All four channels use valid/ready; payloads hold until transfer.
// ----------------------------------------------------------------------
`default_nettype none

module blocking_cache
  import cache_pkg::*;
#(
  parameter int idx_shamt = 0
) (
  input  logic         clk,
  input  logic         reset,

  input  logic         cachereq_val,
  output logic         cachereq_rdy,
  input  cache_req_t   cachereq,

  output logic         cacheresp_val,
  input  logic         cacheresp_rdy,
  output cache_resp_t  cacheresp,

  output logic         memreq_val,
  input  logic         memreq_rdy,
  output line_req_t    memreq,

  input  logic         memresp_val,
  output logic         memresp_rdy,
  input  line_resp_t   memresp
);

  dpath_ctrl_t   ctrl;
  dpath_status_t status;

  // Handshakes live in the controller
  cache_ctrl #(
    .idx_shamt (idx_shamt)
  ) ctrl_i (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .status        (status),
    .ctrl          (ctrl)
  );

  // Payloads live in the datapath
  cache_dpath #(
    .idx_shamt (idx_shamt)
  ) dpath_i (
    .clk       (clk),
    .reset     (reset),
    .cachereq  (cachereq),
    .cacheresp (cacheresp),
    .memreq    (memreq),
    .memresp   (memresp),
    .ctrl      (ctrl),
    .status    (status)
  );

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl.sv ====
// ----------------------------------------------------------------------
// Cache controller. One request in flight; misses evict a dirty LRU
// line before the refill, then the request is replayed.
// ----------------------------------------------------------------------
`default_nettype none

module cache_ctrl
  import cache_pkg::*;
#(
  parameter int idx_shamt = 0
) (
  input  logic           clk,
  input  logic           reset,
  input  logic           cachereq_val,
  output logic           cachereq_rdy,
  output logic           cacheresp_val,
  input  logic           cacheresp_rdy,
  output logic           memreq_val,
  input  logic           memreq_rdy,
  input  logic           memresp_val,
  output logic           memresp_rdy,
  input  dpath_status_t  status,
  output dpath_ctrl_t    ctrl
);

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    READ_ACCESS,
    WRITE_ACCESS,
    INIT_ACCESS,
    AMO_READ,
    AMO_WRITE,
    REFILL_REQUEST,
    REFILL_WAIT,
    REFILL_UPDATE,
    EVICT_PREPARE,
    EVICT_REQUEST,
    EVICT_WAIT,
    WAIT
  } state_e;

  state_e state, state_next;

  logic hit;
  logic victim_dirty;
  logic way;
  logic record_way;
  logic valid_wen;
  logic dirty_wen;
  logic dirty_in;
  logic lru_wen;
  logic is_amo;

  cache_state_bits #(
    .idx_shamt (idx_shamt)
  ) state_bits_i (
    .clk          (clk),
    .reset        (reset),
    .index        (status.idx),
    .tag_match    (status.tag_match),
    .record_way   (record_way),
    .valid_wen    (valid_wen),
    .dirty_wen    (dirty_wen),
    .dirty_in     (dirty_in),
    .lru_wen      (lru_wen),
    .hit          (hit),
    .victim_dirty (victim_dirty),
    .way          (way)
  );

  assign is_amo = (status.req_type == AMO_ADD) || (status.req_type == AMO_AND) ||
                  (status.req_type == AMO_OR);

  // ----------------------------------------------------------------------
  // Next state
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:           if (cachereq_val) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (status.req_type == WRITE_INIT) state_next = INIT_ACCESS;
        else if (!hit)                     state_next = victim_dirty ? EVICT_PREPARE
                                                                     : REFILL_REQUEST;
        else if (is_amo)                   state_next = AMO_READ;
        else if (status.req_type == WRITE) state_next = WRITE_ACCESS;
        else                               state_next = READ_ACCESS;
      end
      READ_ACCESS,
      WRITE_ACCESS,
      INIT_ACCESS,
      AMO_WRITE:      state_next = WAIT;
      AMO_READ:       state_next = AMO_WRITE;
      REFILL_REQUEST: if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:    if (memresp_val) state_next = REFILL_UPDATE;
      // Replay of the original request
      REFILL_UPDATE: begin
        if (is_amo)                        state_next = AMO_READ;
        else if (status.req_type == WRITE) state_next = WRITE_ACCESS;
        else                               state_next = READ_ACCESS;
      end
      EVICT_PREPARE:  state_next = EVICT_REQUEST;
      EVICT_REQUEST:  if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:     if (memresp_val) state_next = REFILL_REQUEST;
      WAIT:           if (cacheresp_rdy) state_next = IDLE;
      default:        state_next = IDLE;
    endcase
  end

  // ----------------------------------------------------------------------
  // Output table
  // ----------------------------------------------------------------------

  task automatic cs(
    input logic      req_rdy,
    input logic      resp_val,
    input logic      mreq_val,
    input logic      mresp_rdy,
    input logic      req_en,
    input logic      mresp_en,
    input logic      refill,
    input logic      tag_wen,
    input logic      tag_ren,
    input logic      data_wen,
    input logic      data_ren,
    input logic      rd_reg_en,
    input logic      resp_en,
    input logic      amo_en,
    input mem_type_e mtype,
    input logic      v_wen,
    input logic      d_wen,
    input logic      d_in,
    input logic      l_wen,
    input logic      record
  );
    cachereq_rdy     = req_rdy;
    cacheresp_val    = resp_val;
    memreq_val       = mreq_val;
    memresp_rdy      = mresp_rdy;
    ctrl.req_en      = req_en;
    ctrl.memresp_en  = mresp_en;
    ctrl.is_refill   = refill;
    ctrl.tag_wen     = tag_wen;
    ctrl.tag_ren     = tag_ren;
    ctrl.data_wen    = data_wen;
    ctrl.data_ren    = data_ren;
    ctrl.read_reg_en = rd_reg_en;
    ctrl.resp_en     = resp_en;
    ctrl.amo_en      = amo_en;
    ctrl.mem_type    = mtype;
    valid_wen        = v_wen;
    dirty_wen        = d_wen;
    dirty_in         = d_in;
    lru_wen          = l_wen;
    record_way       = record;
  endtask

  always_comb begin
    cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, MEM_READ, 0, 0, 0, 0, 0);
    ctrl.way = way;
    case (state)
      //                 rq vl mq ms re me rf tw tr dw dr rr rs am mtype      vw dy di lw rc
      IDLE:           cs(1, 0, 0, 0, 1, 0, 0, 0, 1, 0, 1, 0, 0, 0, MEM_READ,  0, 0, 0, 0, 0);
      TAG_CHECK:      cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, MEM_READ,  0, 0, 0, 0, 1);
      READ_ACCESS:    cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, MEM_READ,  0, 0, 0, 1, 0);
      WRITE_ACCESS:   cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 1, 0, MEM_READ,  0, 1, 1, 1, 0);
      INIT_ACCESS:    cs(0, 0, 0, 0, 0, 0, 0, 1, 0, 1, 0, 0, 1, 0, MEM_READ,  1, 1, 0, 1, 0);
      AMO_READ:       cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, MEM_READ,  0, 0, 0, 0, 0);
      AMO_WRITE:      cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1, MEM_READ,  0, 1, 1, 1, 0);
      REFILL_REQUEST: cs(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, MEM_READ,  0, 0, 0, 0, 0);
      REFILL_WAIT:    cs(0, 0, 0, 1, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, MEM_READ,  0, 0, 0, 0, 0);
      REFILL_UPDATE:  cs(0, 0, 0, 0, 0, 0, 1, 1, 0, 1, 1, 0, 0, 0, MEM_READ,  1, 1, 0, 0, 0);
      EVICT_PREPARE:  cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, MEM_WRITE, 0, 0, 0, 0, 0);
      EVICT_REQUEST:  cs(0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, MEM_READ,  0, 0, 0, 0, 0);
      EVICT_WAIT:     cs(0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, MEM_READ,  0, 0, 0, 0, 0);
      WAIT:           cs(0, 1, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, MEM_READ,  0, 0, 0, 0, 0);
      default:        cs(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, MEM_READ,  0, 0, 0, 0, 0);
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/cache_dpath.sv ====
// ----------------------------------------------------------------------
// Cache datapath. Tags hold the whole line address, so any index shift
// works. Array reads are registered; a refill write bypasses the read.
// ----------------------------------------------------------------------
`default_nettype none

module cache_dpath
  import cache_pkg::*;
#(
  parameter int idx_shamt = 0
) (
  input  logic           clk,
  input  logic           reset,
  input  cache_req_t     cachereq,
  output cache_resp_t    cacheresp,
  output line_req_t      memreq,
  input  line_resp_t     memresp,
  input  dpath_ctrl_t    ctrl,
  output dpath_status_t  status
);

  localparam int TAG_W  = ADDR_W - OFS_W;
  localparam int WORD_W = $clog2(WORDS_PER_LINE);

  cache_req_t             req_q;
  logic [TAG_W-1:0]       tag_array  [NUM_WAYS][NUM_SETS];
  logic [LINE_W-1:0]      data_array [NUM_WAYS][NUM_SETS];
  logic [TAG_W-1:0]       tag_rd     [NUM_WAYS];
  logic [LINE_W-1:0]      data_rd    [NUM_WAYS];
  logic [LINE_W-1:0]      refill_line;
  logic [TAG_W-1:0]       req_tag;
  logic [IDX_W-1:0]       req_idx;
  logic [IDX_W-1:0]       rd_idx;
  logic [WORD_W-1:0]      word_ofs;
  logic [DATA_W-1:0]      old_word;
  logic [DATA_W-1:0]      amo_word;
  logic [DATA_W-1:0]      wr_word;

  assign req_tag  = req_q.addr[ADDR_W-1:OFS_W];
  assign req_idx  = req_q.addr[OFS_W+idx_shamt +: IDX_W];
  assign word_ofs = req_q.addr[2 +: WORD_W];

  // Arrays are read with the incoming index while a request is taken
  assign rd_idx = ctrl.req_en ? cachereq.addr[OFS_W+idx_shamt +: IDX_W] : req_idx;

  always_ff @(posedge clk) begin
    if (ctrl.req_en) begin
      req_q <= cachereq;
    end
    if (ctrl.memresp_en) begin
      refill_line <= memresp.data;
    end
  end

  // ----------------------------------------------------------------------
  // Tag and data arrays
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (ctrl.tag_ren) begin
        tag_rd[w] <= tag_array[w][rd_idx];
      end
      if (ctrl.data_ren) begin
        if (ctrl.data_wen && ctrl.is_refill && (ctrl.way == w[0])) begin
          data_rd[w] <= refill_line;
        end else begin
          data_rd[w] <= data_array[w][rd_idx];
        end
      end
    end
    if (ctrl.tag_wen) begin
      tag_array[ctrl.way][req_idx] <= req_tag;
    end
    // Whole line on refill, else only the addressed word
    if (ctrl.data_wen) begin
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
        if (ctrl.is_refill) begin
          data_array[ctrl.way][req_idx][i*DATA_W +: DATA_W] <= refill_line[i*DATA_W +: DATA_W];
        end else if (i[WORD_W-1:0] == word_ofs) begin
          data_array[ctrl.way][req_idx][i*DATA_W +: DATA_W] <= wr_word;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Atomic unit
  // ----------------------------------------------------------------------

  assign old_word = data_rd[ctrl.way][word_ofs*DATA_W +: DATA_W];

  always_comb begin
    case (req_q.req_type)
      AMO_ADD: amo_word = old_word + req_q.data;
      AMO_AND: amo_word = old_word & req_q.data;
      AMO_OR:  amo_word = old_word | req_q.data;
      default: amo_word = req_q.data;
    endcase
  end

  assign wr_word = ctrl.amo_en ? amo_word : req_q.data;

  // ----------------------------------------------------------------------
  // Response and memory request registers
  // ----------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      cacheresp <= '0;
    end else if (ctrl.resp_en) begin
      cacheresp.resp_type <= req_q.req_type;
      if ((req_q.req_type == WRITE) || (req_q.req_type == WRITE_INIT)) begin
        cacheresp.data <= '0;
      end else begin
        cacheresp.data <= old_word;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      memreq <= '0;
    end else if (ctrl.read_reg_en) begin
      memreq.mem_type <= ctrl.mem_type;
      if (ctrl.mem_type == MEM_WRITE) begin
        // Victim line goes back to its own address
        memreq.addr <= {tag_rd[ctrl.way], {OFS_W{1'b0}}};
        memreq.data <= data_rd[ctrl.way];
      end else begin
        memreq.addr <= {req_tag, {OFS_W{1'b0}}};
        memreq.data <= '0;
      end
    end
  end

  always_comb begin
    status.req_type = req_q.req_type;
    status.idx      = req_idx;
    for (int w = 0; w < NUM_WAYS; w++) begin
      status.tag_match[w] = (tag_rd[w] == req_tag);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/cache_pkg.sv ====
// ----------------------------------------------------------------------
// Shared widths, opcodes and message bundles of the blocking cache.
// Geometry is fixed at 2 ways, 8 sets and 16-byte lines.
// ----------------------------------------------------------------------
`default_nettype none

package cache_pkg;

  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int LINE_W         = 128;
  localparam int WORDS_PER_LINE = 4;
  localparam int NUM_SETS       = 8;
  localparam int NUM_WAYS       = 2;
  localparam int IDX_W          = 3;
  localparam int OFS_W          = 4;

  // ----------------------------------------------------------------------
  // Opcodes
  // ----------------------------------------------------------------------

  typedef enum logic [2:0] {
    READ       = 3'd0,
    WRITE      = 3'd1,
    WRITE_INIT = 3'd2,
    AMO_ADD    = 3'd3,
    AMO_AND    = 3'd4,
    AMO_OR     = 3'd5
  } req_type_e;

  // Refill reads, eviction writes
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_type_e;

  // ----------------------------------------------------------------------
  // Messages
  // ----------------------------------------------------------------------

  typedef struct packed {
    req_type_e          req_type;
    logic [ADDR_W-1:0]  addr;
    logic [DATA_W-1:0]  data;
  } cache_req_t;

  typedef struct packed {
    req_type_e          resp_type;
    logic [DATA_W-1:0]  data;
  } cache_resp_t;

  typedef struct packed {
    mem_type_e          mem_type;
    logic [ADDR_W-1:0]  addr;
    logic [LINE_W-1:0]  data;
  } line_req_t;

  typedef struct packed {
    logic [LINE_W-1:0]  data;
  } line_resp_t;

  // ----------------------------------------------------------------------
  // Control and status between controller and datapath
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic       req_en;
    logic       memresp_en;
    logic       is_refill;
    logic       tag_wen;
    logic       tag_ren;
    logic       data_wen;
    logic       data_ren;
    logic       read_reg_en;
    logic       resp_en;
    logic       amo_en;
    mem_type_e  mem_type;
    logic       way;
  } dpath_ctrl_t;

  typedef struct packed {
    req_type_e             req_type;
    logic [IDX_W-1:0]      idx;
    logic [NUM_WAYS-1:0]   tag_match;
  } dpath_status_t;

endpackage

`default_nettype wire

// ==== verilog/cache_state_bits.sv ====
// ----------------------------------------------------------------------
// Valid, dirty and LRU bits per set. Reads are combinational,
// writes land on the next edge and always target the recorded way.
// ----------------------------------------------------------------------
`default_nettype none

module cache_state_bits
  import cache_pkg::*;
#(
  parameter int idx_shamt = 0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic [IDX_W-1:0]     index,
  input  logic [NUM_WAYS-1:0]  tag_match,
  input  logic                 record_way,
  input  logic                 valid_wen,
  input  logic                 dirty_wen,
  input  logic                 dirty_in,
  input  logic                 lru_wen,
  output logic                 hit,
  output logic                 victim_dirty,
  output logic                 way
);

  logic [NUM_SETS-1:0] valid_bits [NUM_WAYS];
  logic [NUM_SETS-1:0] dirty_bits [NUM_WAYS];
  logic [NUM_SETS-1:0] lru_bits;
  logic [NUM_WAYS-1:0] way_hit;
  logic                lru_way;
  logic                way_q;

  always_comb begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      way_hit[w] = valid_bits[w][index] && tag_match[w];
    end
  end

  assign hit          = |way_hit;
  assign lru_way      = lru_bits[index];
  assign victim_dirty = dirty_bits[lru_way][index];
  assign way          = way_q;

  // Hitting way wins, otherwise replace the LRU way
  always_ff @(posedge clk) begin
    if (reset) begin
      way_q <= 1'b0;
    end else if (record_way) begin
      way_q <= hit ? way_hit[1] : lru_way;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        valid_bits[w] <= '0;
        dirty_bits[w] <= '0;
      end
      lru_bits <= '0;
    end else begin
      if (valid_wen) begin
        valid_bits[way_q][index] <= 1'b1;
      end
      if (dirty_wen) begin
        dirty_bits[way_q][index] <= dirty_in;
      end
      // The other way becomes least recently used
      if (lru_wen) begin
        lru_bits[index] <= ~way_q;
      end
    end
  end

endmodule

`default_nettype wire
